/* gpu_raster.f */
hdl/gpu_types_pkg.sv
hdl/gpu_regmap_pkg.sv
hdl/mem_cmd_if.sv
hdl/gpu_csr.sv
hdl/gpu_control.sv
hdl/clear_walker.sv
hdl/pixel_plotter.sv
hdl/mem_master.sv
hdl/gpu_top.sv
tests/gpu_mem_model.sv
tests/gpu_tb.sv

/* hdl/clear_walker.sv */
// walks fb_width*fb_height words from the selected base; begin_clear has priority over step
`timescale 1ns/1ns
`default_nettype none

module clear_walker import gpu_types_pkg::*, gpu_regmap_pkg::*; #(
    parameter int fb_width  = 640,
    parameter int fb_height = 480
) (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      begin_clear,
    input  logic      step,
    input  gpu_mode_e mode,
    input  addr_t     frame_base,
    input  addr_t     depth_base,
    output addr_t     addr,
    output word_t     word,
    output logic      last
);

    localparam pix_index_t LAST_INDEX = pix_index_t'(fb_width * fb_height - 1);

    pix_index_t count;
    logic       to_depth;

    always_ff @(posedge CLK) begin
        if (RESET || begin_clear)
            count <= '0;
        else if (step)
            count <= count + 1'b1;
    end

    assign to_depth = (mode == MODE_CLEAR_DEPTH);
    assign addr = (to_depth ? depth_base : frame_base) + count * BYTES_PER_PIXEL;
    assign word = to_depth ? CLEAR_DEPTH : CLEAR_COLOR;
    assign last = (count == LAST_INDEX);  // final pixel of the buffer

endmodule

`default_nettype wire

/* hdl/gpu_control.sv */
// job sequencer; start must be cleared by the host before the next job, mode must stay stable during a job
`timescale 1ns/1ns
`default_nettype none

module gpu_control import gpu_types_pkg::*, gpu_regmap_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      start,
    input  gpu_mode_e mode,
    output logic      done_set,
    output logic      clear_step,
    input  logic      clear_last,
    input  logic      plot_ok,
    input  addr_t     plot_depth_addr,
    input  addr_t     plot_color_addr,
    input  word_t     plot_color_word,
    input  word_t     plot_depth_word,
    mem_cmd_if.client mem,
    input  addr_t     clear_addr,
    input  word_t     clear_word,
    output word_t     stored_depth
);

    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_FINISHED} job_state_e;
    typedef enum logic [1:0] {PH_DEPTH_READ, PH_COLOR_WRITE, PH_DEPTH_WRITE} plot_phase_e;

    job_state_e  state, state_next;
    plot_phase_e phase, phase_next;

    always_comb begin
        state_next  = state;
        phase_next  = phase;
        done_set    = 1'b0;
        clear_step  = 1'b0;
        mem.req     = 1'b0;
        mem.write   = 1'b0;
        mem.address = clear_addr;  // clear walker unless a plot phase overrides
        mem.wdata   = clear_word;
        case (state)
            ST_IDLE: begin
                phase_next = PH_DEPTH_READ;
                if (start) begin
                    if (mode == MODE_NONE)
                        done_set = 1'b1;
                    else
                        state_next = ST_RUN;
                end
            end
            ST_RUN: begin
                if (mode == MODE_PLOT) begin
                    case (phase)
                        PH_DEPTH_READ: begin
                            mem.req     = 1'b1;
                            mem.address = plot_depth_addr;
                            if (mem.ack)
                                phase_next = PH_COLOR_WRITE;
                        end
                        PH_COLOR_WRITE: begin
                            if (!plot_ok) begin
                                done_set = 1'b1;  // out of frame or hidden
                            end else begin
                                mem.req     = 1'b1;
                                mem.write   = 1'b1;
                                mem.address = plot_color_addr;
                                mem.wdata   = plot_color_word;
                                if (mem.ack)
                                    phase_next = PH_DEPTH_WRITE;
                            end
                        end
                        PH_DEPTH_WRITE: begin
                            mem.req     = 1'b1;
                            mem.write   = 1'b1;
                            mem.address = plot_depth_addr;
                            mem.wdata   = plot_depth_word;
                            done_set    = mem.ack;
                        end
                        default: phase_next = PH_DEPTH_READ;
                    endcase
                end else if (mode != MODE_NONE) begin
                    mem.req    = 1'b1;  // one write per pixel
                    mem.write  = 1'b1;
                    clear_step = mem.ack;
                    done_set   = mem.ack && clear_last;
                end else begin
                    done_set = 1'b1;
                end
            end
            ST_FINISHED: begin
                if (!start)
                    state_next = ST_IDLE;
            end
            default: state_next = ST_IDLE;
        endcase
        if (done_set)
            state_next = ST_FINISHED;
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state        <= ST_IDLE;
            phase        <= PH_DEPTH_READ;
            stored_depth <= '0;
        end else begin
            state <= state_next;
            phase <= phase_next;
            if (state == ST_RUN && mode == MODE_PLOT && phase == PH_DEPTH_READ && mem.ack)
                stored_depth <= mem.rdata;
        end
    end

endmodule

`default_nettype wire

/* hdl/gpu_csr.sv */
// host register bank; reads are combinational and unmapped offsets return 0, done_set beats host writes
`timescale 1ns/1ns
`default_nettype none

module gpu_csr import gpu_types_pkg::*, gpu_regmap_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      chipselect,
    input  logic      read,
    input  logic      write,
    input  reg_addr_t address,
    input  word_t     writedata,
    output word_t     readdata,
    input  logic      done_set,
    output addr_t     frame_base,
    output addr_t     depth_base,
    output logic      start,
    output gpu_mode_e mode,
    output fixed_t    px,
    output fixed_t    py,
    output fixed_t    pz,
    output rgb_t      color
);

    logic done_q;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            frame_base <= '0;
            depth_base <= '0;
            start      <= 1'b0;
            done_q     <= 1'b0;
            mode       <= MODE_NONE;
            px         <= '0;
            py         <= '0;
            pz         <= '0;
            color      <= '0;
        end else begin
            if (chipselect && write) begin
                case (address)
                    REG_FRAME_BASE: frame_base <= writedata;
                    REG_START:      start      <= writedata[0];
                    REG_DONE:       done_q     <= writedata[0];
                    REG_DEPTH_BASE: depth_base <= writedata;
                    REG_X:          px         <= fixed_t'(writedata);
                    REG_Y:          py         <= fixed_t'(writedata);
                    REG_Z:          pz         <= fixed_t'(writedata);
                    REG_MODE:       mode       <= gpu_mode_e'(writedata[1:0]);
                    REG_COLOR:      color      <= writedata[23:0];
                    default:        ;
                endcase
            end
            if (done_set)
                done_q <= 1'b1;  // job end wins over a host clear
        end
    end

    // read mux
    always_comb begin
        readdata = '0;
        if (chipselect && read) begin
            case (address)
                REG_FRAME_BASE: readdata = frame_base;
                REG_START:      readdata = word_t'(start);
                REG_DONE:       readdata = word_t'(done_q);
                REG_DEPTH_BASE: readdata = depth_base;
                REG_X:          readdata = word_t'(px);
                REG_Y:          readdata = word_t'(py);
                REG_Z:          readdata = word_t'(pz);
                REG_MODE:       readdata = word_t'(mode);
                REG_COLOR:      readdata = word_t'(color);
                default:        readdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/gpu_regmap_pkg.sv */
// host register map and job constants; one 32-bit word per offset, offsets above 8 are unmapped
`default_nettype none

package gpu_regmap_pkg;
    import gpu_types_pkg::*;

    typedef logic [3:0] reg_addr_t;

    localparam reg_addr_t REG_FRAME_BASE = 4'd0;
    localparam reg_addr_t REG_START      = 4'd1;
    localparam reg_addr_t REG_DONE       = 4'd2;
    localparam reg_addr_t REG_DEPTH_BASE = 4'd3;
    localparam reg_addr_t REG_X          = 4'd4;
    localparam reg_addr_t REG_Y          = 4'd5;
    localparam reg_addr_t REG_Z          = 4'd6;
    localparam reg_addr_t REG_MODE       = 4'd7;
    localparam reg_addr_t REG_COLOR      = 4'd8;

    // job selected by the mode register
    typedef enum logic [1:0] {
        MODE_NONE        = 2'd0,
        MODE_PLOT        = 2'd1,
        MODE_CLEAR_FRAME = 2'd2,
        MODE_CLEAR_DEPTH = 2'd3
    } gpu_mode_e;

    localparam int FRAC_BITS = 8;

    localparam word_t CLEAR_COLOR = 32'h0020_3020;  // background
    localparam word_t CLEAR_DEPTH = 32'h7FFF_FFFF;  // farthest depth, signed

    localparam int unsigned BYTES_PER_PIXEL = 4;

endpackage

`default_nettype wire

/* hdl/gpu_top.sv */
// raster engine top; frame size fixed by fb_width and fb_height, buffers are one 32-bit word per pixel
`timescale 1ns/1ns
`default_nettype none

module gpu_top import gpu_types_pkg::*, gpu_regmap_pkg::*; #(
    parameter int fb_width  = 640,
    parameter int fb_height = 480
) (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      slave_chipselect,
    input  logic      slave_read,
    input  logic      slave_write,
    input  reg_addr_t slave_address,
    input  word_t     slave_writedata,
    output word_t     slave_readdata,
    output addr_t     master_address,
    output logic      master_read,
    output logic      master_write,
    output word_t     master_writedata,
    input  logic      master_waitrequest,
    input  word_t     master_readdata,
    input  logic      master_readdatavalid,
    input  logic      master_writeresponsevalid
);

    addr_t     frame_base, depth_base;
    logic      start;
    gpu_mode_e mode;
    fixed_t    px, py, pz;
    rgb_t      color;
    logic      done_set;
    logic      clear_step, clear_last;
    addr_t     clear_addr;
    word_t     clear_word;
    logic      plot_ok;
    addr_t     plot_depth_addr, plot_color_addr;
    word_t     plot_color_word;
    word_t     stored_depth;

    mem_cmd_if mem_bus ();

    gpu_csr u_csr (
        .CLK(CLK), .RESET(RESET),
        .chipselect(slave_chipselect), .read(slave_read), .write(slave_write),
        .address(slave_address), .writedata(slave_writedata), .readdata(slave_readdata),
        .done_set(done_set), .frame_base(frame_base), .depth_base(depth_base),
        .start(start), .mode(mode), .px(px), .py(py), .pz(pz), .color(color)
    );

    gpu_control u_control (
        .CLK(CLK), .RESET(RESET), .start(start), .mode(mode),
        .done_set(done_set), .clear_step(clear_step), .clear_last(clear_last),
        .plot_ok(plot_ok), .plot_depth_addr(plot_depth_addr),
        .plot_color_addr(plot_color_addr), .plot_color_word(plot_color_word),
        .plot_depth_word(word_t'(pz)), .mem(mem_bus.client),
        .clear_addr(clear_addr), .clear_word(clear_word), .stored_depth(stored_depth)
    );

    // walker rewinds at every job end
    clear_walker #(.fb_width(fb_width), .fb_height(fb_height)) u_clear (
        .CLK(CLK), .RESET(RESET), .begin_clear(done_set), .step(clear_step),
        .mode(mode), .frame_base(frame_base), .depth_base(depth_base),
        .addr(clear_addr), .word(clear_word), .last(clear_last)
    );

    pixel_plotter #(.fb_width(fb_width), .fb_height(fb_height)) u_plot (
        .px(px), .py(py), .pz(pz), .color(color),
        .frame_base(frame_base), .depth_base(depth_base), .stored_depth(stored_depth),
        .depth_addr(plot_depth_addr), .color_addr(plot_color_addr),
        .color_word(plot_color_word), .ok(plot_ok)
    );

    mem_master u_master (
        .CLK(CLK), .RESET(RESET), .mem(mem_bus.master),
        .master_address(master_address), .master_read(master_read),
        .master_write(master_write), .master_writedata(master_writedata),
        .master_waitrequest(master_waitrequest), .master_readdata(master_readdata),
        .master_readdatavalid(master_readdatavalid),
        .master_writeresponsevalid(master_writeresponsevalid)
    );

endmodule

`default_nettype wire

/* hdl/gpu_types_pkg.sv */
// shared widths for the raster engine; coordinates and depth are signed 24.8 fixed point
`default_nettype none

package gpu_types_pkg;

    // bus and register word
    typedef logic [31:0] word_t;

    // byte address on the master bus
    typedef logic [31:0] addr_t;

    typedef logic signed [31:0] fixed_t;  // 24.8, integer part in [31:8]

    // linear pixel index, row major
    typedef logic [31:0] pix_index_t;

    typedef logic [23:0] rgb_t;  // packed colour, upper byte of the word stays zero

endpackage

`default_nettype wire

/* hdl/mem_cmd_if.sv */
// one outstanding memory access; req held until the ack pulse, rdata valid only with ack
`timescale 1ns/1ns
`default_nettype none

interface mem_cmd_if import gpu_types_pkg::*; ();

    logic  req;      // held until ack
    logic  write;    // 0 = read
    addr_t address;
    word_t wdata;
    logic  ack;      // one cycle at completion
    word_t rdata;

    modport client (
        output req, write, address, wdata,
        input  ack, rdata
    );

    modport master (
        input  req, write, address, wdata,
        output ack, rdata
    );

endinterface

`default_nettype wire

/* hdl/mem_master.sv */
// master side of the memory bus; one access in flight, request held while waitrequest is high
`timescale 1ns/1ns
`default_nettype none

module mem_master import gpu_types_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    mem_cmd_if.master mem,
    output addr_t     master_address,
    output logic      master_read,
    output logic      master_write,
    output word_t     master_writedata,
    input  logic      master_waitrequest,
    input  word_t     master_readdata,
    input  logic      master_readdatavalid,
    input  logic      master_writeresponsevalid
);

    typedef enum logic [1:0] {M_IDLE, M_REQUEST, M_WAIT_RESP} master_state_e;

    master_state_e state;
    logic          cmd_write;
    addr_t         cmd_addr;
    word_t         cmd_wdata;
    logic          ack_q;
    word_t         rdata_q;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= M_IDLE;
            cmd_write <= 1'b0;
            cmd_addr  <= '0;
            cmd_wdata <= '0;
            ack_q     <= 1'b0;
            rdata_q   <= '0;
        end else begin
            ack_q <= 1'b0;
            case (state)
                M_IDLE: begin
                    // client still holds req during the ack cycle
                    if (mem.req && !ack_q) begin
                        cmd_write <= mem.write;
                        cmd_addr  <= mem.address;
                        cmd_wdata <= mem.wdata;
                        state     <= M_REQUEST;
                    end
                end
                M_REQUEST: begin
                    if (!master_waitrequest)
                        state <= M_WAIT_RESP;  // accepted
                end
                M_WAIT_RESP: begin
                    if (cmd_write ? master_writeresponsevalid : master_readdatavalid) begin
                        ack_q <= 1'b1;
                        if (!cmd_write)
                            rdata_q <= master_readdata;
                        state <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    assign master_address   = cmd_addr;
    assign master_writedata = cmd_wdata;
    assign master_read      = (state == M_REQUEST) && !cmd_write;
    assign master_write     = (state == M_REQUEST) && cmd_write;

    assign mem.ack   = ack_q;
    assign mem.rdata = rdata_q;

endmodule

`default_nettype wire

/* hdl/pixel_plotter.sv */
// single point address and visibility; x and y must be strictly inside the frame, edge pixels 0 are rejected
`timescale 1ns/1ns
`default_nettype none

module pixel_plotter import gpu_types_pkg::*, gpu_regmap_pkg::*; #(
    parameter int fb_width  = 640,
    parameter int fb_height = 480
) (
    input  fixed_t px,
    input  fixed_t py,
    input  fixed_t pz,
    input  rgb_t   color,
    input  addr_t  frame_base,
    input  addr_t  depth_base,
    input  word_t  stored_depth,
    output addr_t  depth_addr,
    output addr_t  color_addr,
    output word_t  color_word,
    output logic   ok
);

    // frame limits in fixed point
    localparam fixed_t X_LIMIT = fixed_t'(fb_width << FRAC_BITS);
    localparam fixed_t Y_LIMIT = fixed_t'(fb_height << FRAC_BITS);

    pix_index_t col;
    pix_index_t row;
    pix_index_t index;
    addr_t      offset;
    logic       in_frame;
    logic       closer;

    assign col    = pix_index_t'(px >>> FRAC_BITS);  // integer parts
    assign row    = pix_index_t'(py >>> FRAC_BITS);
    assign index  = row * pix_index_t'(fb_width) + col;
    assign offset = index * BYTES_PER_PIXEL;

    assign depth_addr = depth_base + offset;
    assign color_addr = frame_base + offset;
    assign color_word = word_t'(color);

    assign in_frame = (px > 0) && (px < X_LIMIT) && (py > 0) && (py < Y_LIMIT);
    assign closer   = fixed_t'(stored_depth) > pz;  // signed depth compare
    assign ok       = in_frame && closer;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# builds gpu_tb with Verilator, runs it and scans sim.log for the fail message
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module gpu_tb -f gpu_raster.f -o gpu_sim \
    && ./obj_dir/gpu_sim 2>&1 | tee sim.log \
    || { echo "build or simulation error"; exit 1; }
grep -q "Verification failed" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "Verification passed" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation ok"

/* tests/gpu_mem_model.sv */
// sparse word memory on the master bus; outputs change on the falling edge, unwritten words read a pattern of the address
`timescale 1ns/1ns
`default_nettype none

module gpu_mem_model import gpu_types_pkg::*; #(
    parameter logic [31:0] seed = 32'd59
) (
    input  logic  CLK,
    input  logic  RESET,
    input  addr_t address,
    input  logic  read,
    input  logic  write,
    input  word_t writedata,
    output logic  waitrequest,
    output word_t readdata,
    output logic  readdatavalid,
    output logic  writeresponsevalid
);

    word_t       mem [addr_t];
    logic [31:0] rand_state    = seed;
    logic        wait_q        = 1'b1;
    logic        rvalid_q      = 1'b0;
    logic        wresp_q       = 1'b0;
    word_t       rdata_q       = '0;
    logic        pending       = 1'b0;
    logic        pending_write = 1'b0;
    int          delay         = 0;  // falling edges left until the response

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic word_t peek(input addr_t a);
        if (mem.exists(a))
            return mem[a];
        return (a * 32'h9E37_79B1) ^ 32'h0F0F_5A5A;  // never written
    endfunction

    function automatic void poke(input addr_t a, input word_t d);
        mem[a] = d;
    endfunction

    always @(negedge CLK) begin
        wait_q   <= 1'b1;
        rvalid_q <= 1'b0;
        wresp_q  <= 1'b0;
        if (RESET) begin
            pending <= 1'b0;
        end else if (pending) begin
            delay <= delay - 1;
            if (delay == 1) begin
                pending  <= 1'b0;
                rvalid_q <= !pending_write;
                wresp_q  <= pending_write;
            end
        end else if (read || write) begin
            rand_state = lcg_next(rand_state);
            if (rand_state[17]) begin
                wait_q        <= 1'b0;  // accepted at the next rising edge
                pending       <= 1'b1;
                pending_write <= write;
                delay         <= 1 + int'(rand_state[23:22]) % 3;
                if (write)
                    mem[address] = writedata;
                else
                    rdata_q <= peek(address);
            end
        end
    end

    assign waitrequest        = wait_q;
    assign readdata           = rdata_q;
    assign readdatavalid      = rvalid_q;
    assign writeresponsevalid = wresp_q;

endmodule

`default_nettype wire

/* tests/gpu_tb.sv */
// testbench for gpu_top with an 8x6 frame; buffers at fixed bases, one job at a time
`timescale 1ns/1ns
`default_nettype none

module gpu_tb import gpu_types_pkg::*, gpu_regmap_pkg::*; ();

    localparam int    FB_W           = 8;
    localparam int    FB_H           = 6;
    localparam int    PIXELS         = FB_W * FB_H;
    localparam int    NUM_TESTS      = 6;
    localparam int    TIMEOUT_CYCLES = NUM_TESTS * PIXELS * 20;
    localparam addr_t FRAME_BASE     = 32'h0000_1000;
    localparam addr_t DEPTH_BASE     = 32'h0000_2000;

    logic      CLK;
    logic      RESET;
    logic      slave_chipselect, slave_read, slave_write;
    reg_addr_t slave_address;
    word_t     slave_writedata, slave_readdata;
    addr_t     master_address;
    logic      master_read, master_write, master_waitrequest;
    word_t     master_writedata, master_readdata;
    logic      master_readdatavalid, master_writeresponsevalid;

    word_t       shadow [addr_t];  // expected memory contents
    word_t       reg_vals [9];
    string       test_name       = "";
    int          tests_run       = 0;
    int          checks          = 0;
    int          errors          = 0;
    int          errors_at_start = 0;
    int          check_req       = 0;
    int          check_ack       = 0;
    logic [31:0] rand_state;

    gpu_top #(.fb_width(FB_W), .fb_height(FB_H)) u_dut (
        .CLK(CLK), .RESET(RESET),
        .slave_chipselect(slave_chipselect), .slave_read(slave_read),
        .slave_write(slave_write), .slave_address(slave_address),
        .slave_writedata(slave_writedata), .slave_readdata(slave_readdata),
        .master_address(master_address), .master_read(master_read),
        .master_write(master_write), .master_writedata(master_writedata),
        .master_waitrequest(master_waitrequest), .master_readdata(master_readdata),
        .master_readdatavalid(master_readdatavalid),
        .master_writeresponsevalid(master_writeresponsevalid)
    );

    gpu_mem_model #(.seed(32'd59)) u_mem (
        .CLK(CLK), .RESET(RESET), .address(master_address), .read(master_read),
        .write(master_write), .writedata(master_writedata),
        .waitrequest(master_waitrequest), .readdata(master_readdata),
        .readdatavalid(master_readdatavalid), .writeresponsevalid(master_writeresponsevalid)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic addr_t word_addr(input addr_t base, input int index);
        return base + addr_t'(index) * BYTES_PER_PIXEL;
    endfunction

    // expected word from the shadow or the model's fill pattern
    function automatic word_t expected_word(input addr_t a);
        if (shadow.exists(a))
            return shadow[a];
        return (a * 32'h9E37_79B1) ^ 32'h0F0F_5A5A;
    endfunction

    function automatic void model_clear(input addr_t base, input word_t value);
        for (int i = 0; i < PIXELS; i++)
            shadow[word_addr(base, i)] = value;
    endfunction

    // visible only strictly inside the frame and nearer than the stored depth
    function automatic void model_plot(input fixed_t x, input fixed_t y, input fixed_t z,
                                       input word_t color);
        int    col;
        int    row;
        addr_t off;
        col = int'(x >>> FRAC_BITS);
        row = int'(y >>> FRAC_BITS);
        off = addr_t'(row * FB_W + col) * BYTES_PER_PIXEL;
        if (x <= 0 || y <= 0 || x >= fixed_t'(FB_W << FRAC_BITS)
                || y >= fixed_t'(FB_H << FRAC_BITS))
            return;
        if (fixed_t'(expected_word(DEPTH_BASE + off)) > z) begin
            shadow[FRAME_BASE + off] = color;
            shadow[DEPTH_BASE + off] = word_t'(z);
        end
    endfunction

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, test_name, errors - errors_at_start);
    endtask

    task automatic write_reg(input reg_addr_t a, input word_t d);
        @(negedge CLK);
        slave_chipselect = 1'b1;
        slave_write      = 1'b1;
        slave_address    = a;
        slave_writedata  = d;
        @(negedge CLK);
        slave_chipselect = 1'b0;
        slave_write      = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t a, output word_t d);
        @(negedge CLK);
        slave_chipselect = 1'b1;
        slave_read       = 1'b1;
        slave_address    = a;
        #5;
        d = slave_readdata;  // mux settled by mid low phase
        @(negedge CLK);
        slave_chipselect = 1'b0;
        slave_read       = 1'b0;
    endtask

    task automatic wait_done();
        word_t d;
        d = '0;
        while (d[0] !== 1'b1)
            read_reg(REG_DONE, d);
    endtask

    task automatic run_job(input gpu_mode_e job);
        word_t d;
        write_reg(REG_MODE, word_t'(job));
        write_reg(REG_START, 32'd1);
        wait_done();
        read_reg(REG_DONE, d);
        check_value("done after job", 32'd1, d);
        write_reg(REG_START, 32'd0);
        write_reg(REG_DONE, 32'd0);
        read_reg(REG_DONE, d);
        check_value("done after clear", 32'd0, d);
    endtask

    task automatic compare_buffers();
        check_req++;
        wait (check_ack == check_req);
    endtask

    task automatic plot(input fixed_t x, input fixed_t y, input fixed_t z, input word_t color);
        write_reg(REG_X, word_t'(x));
        write_reg(REG_Y, word_t'(y));
        write_reg(REG_Z, word_t'(z));
        write_reg(REG_COLOR, color);
        model_plot(x, y, z, color);
        run_job(MODE_PLOT);
        compare_buffers();
    endtask

    // both buffers and the word just past each one against the reference
    initial begin
        forever begin
            wait (check_ack != check_req);
            for (int i = 0; i <= PIXELS; i++) begin
                check_value($sformatf("frame word %0d", i),
                            expected_word(word_addr(FRAME_BASE, i)),
                            u_mem.peek(word_addr(FRAME_BASE, i)));
                check_value($sformatf("depth word %0d", i),
                            expected_word(word_addr(DEPTH_BASE, i)),
                            u_mem.peek(word_addr(DEPTH_BASE, i)));
            end
            check_ack++;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        word_t d;
        word_t expected;
        RESET            = 1'b1;
        slave_chipselect = 1'b0;
        slave_read       = 1'b0;
        slave_write      = 1'b0;
        slave_address    = '0;
        slave_writedata  = '0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        // random contents so untouched words stand out
        rand_state = 32'd59;
        for (int i = 0; i < PIXELS; i++) begin
            rand_state = lcg_next(rand_state);
            u_mem.poke(word_addr(FRAME_BASE, i), rand_state);
            shadow[word_addr(FRAME_BASE, i)] = rand_state;
            rand_state = lcg_next(rand_state);
            u_mem.poke(word_addr(DEPTH_BASE, i), rand_state);
            shadow[word_addr(DEPTH_BASE, i)] = rand_state;
        end

        begin_test("register_access");
        reg_vals = '{FRAME_BASE, 32'd0, 32'd1, DEPTH_BASE, 32'h0000_0380,
                     32'hFFFF_FE40, 32'h1234_5678, 32'd3, 32'h00AB_CDEF};
        for (int i = 0; i < 9; i++)
            write_reg(reg_addr_t'(i), reg_vals[i]);
        for (int i = 0; i < 16; i++) begin
            read_reg(reg_addr_t'(i), d);
            expected = '0;  // unmapped offsets
            if (i < 9)
                expected = reg_vals[i];
            check_value($sformatf("register %0d", i), expected, d);
        end
        write_reg(REG_MODE, 32'd0);
        write_reg(REG_DONE, 32'd0);
        end_test();

        begin_test("frame_clear");
        model_clear(FRAME_BASE, CLEAR_COLOR);
        run_job(MODE_CLEAR_FRAME);
        compare_buffers();
        end_test();

        begin_test("depth_clear");
        model_clear(DEPTH_BASE, CLEAR_DEPTH);
        run_job(MODE_CLEAR_DEPTH);
        compare_buffers();
        end_test();

        begin_test("plot_visible");
        plot(32'sh380, 32'sh240, 32'sh6400, 32'h0011_2233);  // pixel (3, 2) at index 19
        check_value("plot colour word", 32'h0011_2233, u_mem.peek(word_addr(FRAME_BASE, 19)));
        check_value("plot depth word", 32'h0000_6400, u_mem.peek(word_addr(DEPTH_BASE, 19)));
        end_test();

        begin_test("plot_rejected");
        plot(32'sh380, 32'sh240, 32'sh6400, 32'h00FF_0000);  // equal depth
        plot(32'sh380, 32'sh240, 32'sh7000, 32'h0000_FF00);
        plot(32'sh0, 32'sh240, 32'sh10, 32'h0000_00FF);
        plot(fixed_t'(FB_W << FRAC_BITS), 32'sh240, 32'sh10, 32'h0000_00FF);
        plot(32'sh380, 32'sh0, 32'sh10, 32'h0000_00FF);
        plot(32'sh380, fixed_t'(FB_H << FRAC_BITS), 32'sh10, 32'h0000_00FF);
        plot(32'shFFFF_FF00, 32'sh240, 32'sh10, 32'h0000_00FF);  // negative x
        check_value("kept colour word", 32'h0011_2233, u_mem.peek(word_addr(FRAME_BASE, 19)));
        end_test();

        begin_test("mode_none");
        run_job(MODE_NONE);
        compare_buffers();
        end_test();

        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
